// ==== bench/host_mem_tb.sv ====
// ======================================================================
// testbench for the host memory read adapter with an out of order host
// ======================================================================
`timescale 1ns/1ps
`include "host_mem_settings.svh"

module host_mem_tb import host_mem_pkg::*;
();

    localparam int PAGE = `HM_PAGE_LINES;
    localparam int MAX_SINK = `HM_MAX_SINK_LINES;
    localparam int DEPTH = `HM_ROB_DEPTH;
    localparam logic [63:0] DATA_PATTERN = 64'h5a3c_96e1_0ff0_a55a;
    // 1 + 16 + 28 lines, up to 20 bursts of 16 and 32 stalled lines
    localparam int TOTAL_LINES = 397;
    localparam int CYCLE_LIMIT = TOTAL_LINES * 20 + 300;

    logic clk;
    logic reset;
    logic req_valid;
    hm_rd_req_t req;
    logic req_ready;
    logic rsp_valid;
    hm_rd_rsp_t rsp;
    logic rsp_ready;
    logic host_req_valid;
    hm_host_req_t host_req;
    logic host_req_ready;
    logic host_rsp_valid;
    hm_host_rsp_t host_rsp;

    logic [31:0] lfsr_state = 32'h997c;
    int checks = 0;
    int errors = 0;
    int cycles = 0;
    // lines requested from the host and not yet released to the client
    int outstanding = 0;

    // host model state, one entry per line still owed by the host
    logic [31:0] host_addr_q[$];
    hm_slot_t host_tag_q[$];

    // host pieces expected in order
    logic [31:0] exp_piece_addr_q[$];
    int exp_piece_lines_q[$];

    // client lines expected in order
    logic [3:0] exp_id_q[$];
    logic [63:0] exp_data_q[$];
    logic exp_last_q[$];

    host_mem_read_map i_host_mem_read_map
    (
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req(req),
        .req_ready(req_ready),
        .rsp_valid(rsp_valid),
        .rsp(rsp),
        .rsp_ready(rsp_ready),
        .host_req_valid(host_req_valid),
        .host_req(host_req),
        .host_req_ready(host_req_ready),
        .host_rsp_valid(host_rsp_valid),
        .host_rsp(host_rsp)
    );

    // galois LFSR, one step per bit handed out
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            bits = {bits[30:0], lfsr_state[0]};
            if (lfsr_state[0])
            begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end
            else
            begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return bits;
    endfunction

    // the host memory content is a fixed function of the line address
    function automatic logic [63:0] line_data(input logic [31:0] addr);
        return {addr, ~addr} ^ DATA_PATTERN;
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got,
                            input logic [63:0] expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // transfers are sampled mid cycle and take effect at the next rising edge
    always @(negedge clk)
    begin
        int lines;
        if (!reset)
        begin
            if (host_req_valid && host_req_ready)
            begin
                lines = int'(host_req.len) + 1;
                if (exp_piece_lines_q.size() == 0)
                begin
                    errors++;
                    $display("host request at %0t arrived with no piece expected", $time);
                end
                else
                begin
                    check_eq("host_req.addr", host_req.addr, exp_piece_addr_q.pop_front());
                    check_eq("host_req lines", lines, exp_piece_lines_q.pop_front());
                end
                check_eq("host_req inside one page",
                         int'(host_req.addr % PAGE) + lines <= PAGE, 1);
                outstanding += lines;
                check_eq("host lines beyond released within ROB depth",
                         outstanding <= DEPTH, 1);
                for (int k = 0; k < lines; k++)
                begin
                    host_addr_q.push_back(host_req.addr + k);
                    host_tag_q.push_back(hm_slot_t'(int'(host_req.tag) + k));
                end
            end
            if (rsp_valid && rsp_ready)
            begin
                outstanding--;
                if (exp_id_q.size() == 0)
                begin
                    errors++;
                    $display("client line at %0t arrived with no request open", $time);
                end
                else
                begin
                    check_eq("rsp.id", rsp.id, exp_id_q.pop_front());
                    check_eq("rsp.data", rsp.data, exp_data_q.pop_front());
                    check_eq("rsp.last", rsp.last, exp_last_q.pop_front());
                end
            end
        end
    end

    // host model returns one owed line in random order on most cycles
    initial
    begin
        int pick;
        host_rsp_valid = 1'b0;
        host_rsp = '0;
        host_req_ready = 1'b1;
        forever
        begin
            @(posedge clk);
            #1;
            host_rsp_valid = 1'b0;
            if (host_tag_q.size() > 0 && lfsr_bits(2) != 0)
            begin
                pick = int'(lfsr_bits(5)) % host_tag_q.size();
                host_rsp.tag = host_tag_q[pick];
                host_rsp.data = line_data(host_addr_q[pick]);
                host_rsp_valid = 1'b1;
                host_tag_q.delete(pick);
                host_addr_q.delete(pick);
            end
        end
    end

    // queue the expected lines, then hold the request until it is taken
    task automatic send_burst(input logic [3:0] id, input logic [31:0] addr,
                              input logic [3:0] len);
        logic [31:0] piece_addr;
        int left;
        int n;
        for (int k = 0; k <= int'(len); k++)
        begin
            exp_id_q.push_back(id);
            exp_data_q.push_back(line_data(addr + k));
            exp_last_q.push_back(k == int'(len));
        end
        // each piece ends at whichever comes first of burst end, host maximum and page end
        piece_addr = addr;
        left = int'(len) + 1;
        while (left > 0)
        begin
            n = left;
            if (n > MAX_SINK)
            begin
                n = MAX_SINK;
            end
            if (PAGE - int'(piece_addr % PAGE) < n)
            begin
                n = PAGE - int'(piece_addr % PAGE);
            end
            exp_piece_addr_q.push_back(piece_addr);
            exp_piece_lines_q.push_back(n);
            piece_addr = piece_addr + 32'(n);
            left -= n;
        end
        req.id = id;
        req.addr = addr;
        req.len = len;
        req_valid = 1'b1;
        @(negedge clk);
        while (!req_ready)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_id_q.size() != 0)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %s finished with %0d errors", name, errors - errors_before);
    endtask

    task automatic test_single_line();
        int start;
        start = errors;
        send_burst(4'h5, 32'h0000_1234, 4'd0);
        wait_drain();
        report_test("single line", start);
    endtask

    // 3 lines before the boundary at line 0x140
    task automatic test_page_cross();
        int start;
        start = errors;
        send_burst(4'ha, 32'h0000_013d, 4'd15);
        wait_drain();
        report_test("page crossing burst", start);
    endtask

    task automatic test_back_to_back();
        int start;
        start = errors;
        send_burst(4'h3, 32'h0000_0100, 4'd3);
        send_burst(4'h9, 32'h0000_023e, 4'd7);
        send_burst(4'hc, 32'h0000_7fc0, 4'd15);
        wait_drain();
        report_test("back to back bursts", start);
    endtask

    task automatic test_random_bursts();
        int start;
        logic [3:0] ids[20];
        logic [31:0] addrs[20];
        logic [3:0] lens[20];
        start = errors;
        // drawn while the host owes nothing, so the LFSR sequence is fixed
        for (int i = 0; i < 20; i++)
        begin
            ids[i] = lfsr_bits(4);
            addrs[i] = lfsr_bits(32);
            lens[i] = lfsr_bits(4);
        end
        for (int i = 0; i < 20; i++)
        begin
            send_burst(ids[i], addrs[i], lens[i]);
        end
        wait_drain();
        report_test("random bursts", start);
    endtask

    task automatic test_client_stall();
        int start;
        start = errors;
        rsp_ready = 1'b0;
        send_burst(4'h6, 32'h0000_0400, 4'd15);
        send_burst(4'h7, 32'h0000_0410, 4'd15);
        // the second burst can only get as far as the free slots allow
        repeat (60) @(posedge clk);
        #1;
        check_eq("host lines open during stall", outstanding, DEPTH);
        check_eq("host_req_valid during stall", host_req_valid, 1'b0);
        rsp_ready = 1'b1;
        wait_drain();
        report_test("client stall", start);
    endtask

    initial
    begin
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        rsp_ready = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        test_single_line();
        test_page_cross();
        test_back_to_back();
        test_random_bursts();
        test_client_stall();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the read adapter testbench with Verilator and runs it into a log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f \
    --top-module host_mem_tb \
    -o host_mem_sim

./obj_dir/host_mem_sim | tee sim.log

if grep -q "^RESULT: PASS$" sim.log
then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== source/burst_splitter.sv ====
// ======================================================================
// splits client read bursts into pieces that respect the host maximum
// burst and never cross a page, one client burst at a time
// ======================================================================
`timescale 1ns/1ps
`include "host_mem_settings.svh"

module burst_splitter import host_mem_pkg::*;
(
    input  logic clk,
    input  logic reset,

    input  logic req_valid,
    input  hm_rd_req_t req,
    output logic req_ready,

    output logic piece_valid,
    output hm_piece_t piece,
    input  logic piece_ready
);

    localparam int ADDR_W = `HM_ADDR_W;
    localparam int PAGE_W = $clog2(`HM_PAGE_LINES);
    // wide enough for a full page of lines
    localparam int TAKE_W = PAGE_W + 1;
    // wide enough for a full client burst
    localparam int REM_W = `HM_LEN_W + 1;
    localparam int PLEN_W = `HM_PIECE_LEN_W;

    logic busy;
    logic [ADDR_W-1:0] cur_addr;
    logic [`HM_ID_W-1:0] cur_id;
    logic [REM_W-1:0] remaining;

    logic [TAKE_W-1:0] page_left;
    logic [TAKE_W-1:0] rem_ext;
    logic [TAKE_W-1:0] take;
    logic [TAKE_W-1:0] take_m1;

    // a new burst is taken only once the previous one is fully split
    assign req_ready = !busy;
    assign piece_valid = busy;

    // lines left before the next page boundary
    assign page_left = TAKE_W'(`HM_PAGE_LINES) - TAKE_W'(cur_addr[PAGE_W-1:0]);
    assign rem_ext = TAKE_W'(remaining);

    // the piece is the smallest of the three limits
    always_comb
    begin
        take = rem_ext;
        if (TAKE_W'(`HM_MAX_SINK_LINES) < take)
        begin
            take = TAKE_W'(`HM_MAX_SINK_LINES);
        end
        if (page_left < take)
        begin
            take = page_left;
        end
    end

    assign take_m1 = take - 1'b1;

    // the piece is formed from the registers alone, so it holds while stalled
    assign piece.addr = cur_addr;
    assign piece.len = take_m1[PLEN_W-1:0];
    assign piece.id = cur_id;
    assign piece.last_piece = (take == rem_ext);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy <= 1'b0;
        end
        else if (req_valid && req_ready)
        begin
            busy <= 1'b1;
        end
        else if (piece_valid && piece_ready && piece.last_piece)
        begin
            busy <= 1'b0;
        end
    end

    // address and count advance by one piece on every piece transfer
    always_ff @(posedge clk)
    begin
        if (req_valid && req_ready)
        begin
            cur_addr <= req.addr;
            cur_id <= req.id;
            remaining <= REM_W'(req.len) + 1'b1;
        end
        else if (piece_valid && piece_ready)
        begin
            cur_addr <= cur_addr + ADDR_W'(take);
            remaining <= remaining - REM_W'(take);
        end
    end

    // the final line of a piece must still sit in the page of its first line
    // the short length field must also cover every line the address skips past
    a_piece_in_page : assert property (@(posedge clk) disable iff (reset)
        piece_valid |-> (TAKE_W'(piece.addr[PAGE_W-1:0]) + TAKE_W'(piece.len)
                         < TAKE_W'(`HM_PAGE_LINES))
                        && (TAKE_W'(piece.len) + 1'b1 == take));

endmodule

// ==== source/host_mem_pkg.sv ====
// ======================================================================
// channel payload types of the host memory read adapter
// ======================================================================
`include "host_mem_settings.svh"

package host_mem_pkg;

    // index of one line slot in the reorder buffer
    typedef logic [`HM_SLOT_W-1:0] hm_slot_t;

    // a client read burst, len holds the line count minus one
    typedef struct packed {
        logic [`HM_ID_W-1:0] id;
        logic [`HM_ADDR_W-1:0] addr;
        logic [`HM_LEN_W-1:0] len;
    } hm_rd_req_t;

    // one piece of a client burst that fits the host limits
    typedef struct packed {
        logic [`HM_ADDR_W-1:0] addr;
        logic [`HM_PIECE_LEN_W-1:0] len;
        logic [`HM_ID_W-1:0] id;
        // set on the final piece of the client burst
        logic last_piece;
    } hm_piece_t;

    // a request toward the host, tagged with the slot of its first line
    typedef struct packed {
        logic [`HM_ADDR_W-1:0] addr;
        logic [`HM_PIECE_LEN_W-1:0] len;
        hm_slot_t tag;
    } hm_host_req_t;

    // a single line returned by the host, in any order
    typedef struct packed {
        hm_slot_t tag;
        logic [`HM_DATA_W-1:0] data;
    } hm_host_rsp_t;

    // a line handed back to the client in request order
    typedef struct packed {
        logic [`HM_ID_W-1:0] id;
        logic [`HM_DATA_W-1:0] data;
        logic last;
    } hm_rd_rsp_t;

endpackage

// ==== source/host_mem_read_map.sv ====
// ======================================================================
// read side of the host memory port adapter, from client bursts to
// host pieces and back through the reorder buffer
// ======================================================================
`timescale 1ns/1ps
`include "host_mem_settings.svh"

module host_mem_read_map import host_mem_pkg::*;
(
    input  logic clk,
    input  logic reset,

    // client request and response channels
    input  logic req_valid,
    input  hm_rd_req_t req,
    output logic req_ready,
    output logic rsp_valid,
    output hm_rd_rsp_t rsp,
    input  logic rsp_ready,

    // host request channel and response stream, the latter has no ready
    output logic host_req_valid,
    output hm_host_req_t host_req,
    input  logic host_req_ready,
    input  logic host_rsp_valid,
    input  hm_host_rsp_t host_rsp
);

    logic piece_valid;
    logic piece_ready;
    hm_piece_t piece;

    // slot bookkeeping between the credit block and the reorder buffer
    logic alloc;
    hm_slot_t alloc_slot;
    logic [`HM_PIECE_CNT_W-1:0] alloc_lines;
    logic [`HM_ID_W-1:0] alloc_id;
    logic alloc_last;
    logic free_lines;

    burst_splitter i_burst_splitter
    (
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req(req),
        .req_ready(req_ready),
        .piece_valid(piece_valid),
        .piece(piece),
        .piece_ready(piece_ready)
    );

    rsp_credits i_rsp_credits
    (
        .clk(clk),
        .reset(reset),
        .piece_valid(piece_valid),
        .piece(piece),
        .piece_ready(piece_ready),
        .host_req_valid(host_req_valid),
        .host_req(host_req),
        .host_req_ready(host_req_ready),
        .alloc(alloc),
        .alloc_slot(alloc_slot),
        .alloc_lines(alloc_lines),
        .alloc_id(alloc_id),
        .alloc_last(alloc_last),
        .free_lines(free_lines)
    );

    read_rob i_read_rob
    (
        .clk(clk),
        .reset(reset),
        .alloc(alloc),
        .alloc_slot(alloc_slot),
        .alloc_lines(alloc_lines),
        .alloc_id(alloc_id),
        .alloc_last(alloc_last),
        .host_rsp_valid(host_rsp_valid),
        .host_rsp(host_rsp),
        .rsp_valid(rsp_valid),
        .rsp(rsp),
        .rsp_ready(rsp_ready),
        .free_lines(free_lines)
    );

endmodule

// ==== source/host_mem_settings.svh ====
// ======================================================================
// sizing of the host memory read adapter, shared by the package and RTL
// ======================================================================
`ifndef HOST_MEM_SETTINGS_SVH
`define HOST_MEM_SETTINGS_SVH

// client side fields, where the length field counts lines minus one
`define HM_ADDR_W 32
`define HM_ID_W 4
`define HM_LEN_W 4
`define HM_DATA_W 64

// host side limits, the page size is a power of two
`define HM_MAX_SINK_LINES 4
`define HM_PAGE_LINES 64

// reorder buffer size in lines, also a power of two
`define HM_ROB_DEPTH 16

// widths that follow from the sizes above
`define HM_SLOT_W $clog2(`HM_ROB_DEPTH)
`define HM_PIECE_LEN_W $clog2(`HM_MAX_SINK_LINES)
`define HM_PIECE_CNT_W $clog2(`HM_MAX_SINK_LINES + 1)

`endif

// ==== source/read_rob.sv ====
// ======================================================================
// reorder buffer that collects tagged host lines and hands them to the
// client in request order with the burst ID and last flag
// ======================================================================
`timescale 1ns/1ps
`include "host_mem_settings.svh"

module read_rob import host_mem_pkg::*;
(
    input  logic clk,
    input  logic reset,

    input  logic alloc,
    input  hm_slot_t alloc_slot,
    input  logic [`HM_PIECE_CNT_W-1:0] alloc_lines,
    input  logic [`HM_ID_W-1:0] alloc_id,
    input  logic alloc_last,

    input  logic host_rsp_valid,
    input  hm_host_rsp_t host_rsp,

    output logic rsp_valid,
    output hm_rd_rsp_t rsp,
    input  logic rsp_ready,

    output logic free_lines
);

    localparam int DEPTH = `HM_ROB_DEPTH;

    logic [`HM_DATA_W-1:0] data_mem [DEPTH];
    logic [`HM_ID_W-1:0] id_mem [DEPTH];
    logic last_mem [DEPTH];

    // one bit per slot, set by the host line and cleared by the release
    logic [DEPTH-1:0] filled;
    hm_slot_t head;
    logic release_head;

    // the oldest reserved slot leaves as soon as its line is in
    assign rsp_valid = filled[head];
    assign rsp.id = id_mem[head];
    assign rsp.data = data_mem[head];
    assign rsp.last = last_mem[head];

    assign release_head = rsp_valid && rsp_ready;

    // every released line hands one credit back
    assign free_lines = release_head;

    // metadata for all lines of a piece is written at reservation time
    always_ff @(posedge clk)
    begin
        if (alloc)
        begin
            for (int k = 0; k < `HM_MAX_SINK_LINES; k++)
            begin
                if (k < int'(alloc_lines))
                begin
                    id_mem[alloc_slot + hm_slot_t'(k)] <= alloc_id;
                    // only the final line of the final piece ends the burst
                    last_mem[alloc_slot + hm_slot_t'(k)] <=
                        alloc_last && ((k + 1) == int'(alloc_lines));
                end
            end
        end
    end

    // host lines land directly in the slot named by their tag
    always_ff @(posedge clk)
    begin
        if (host_rsp_valid)
        begin
            data_mem[host_rsp.tag] <= host_rsp.data;
        end
    end

    // the head slot is filled, so the host never writes it while it is released
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            filled <= '0;
            head <= '0;
        end
        else
        begin
            if (release_head)
            begin
                filled[head] <= 1'b0;
                head <= head + 1'b1;
            end
            if (host_rsp_valid)
            begin
                filled[host_rsp.tag] <= 1'b1;
            end
        end
    end

    // a slot must be released before the host may fill it again
    a_no_refill : assert property (@(posedge clk) disable iff (reset)
        host_rsp_valid |-> !filled[host_rsp.tag]);

    // the client sees a steady line until it accepts it
    a_rsp_stable : assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

// ==== source/rsp_credits.sv ====
// ======================================================================
// reserves reorder slots for each piece and holds the host request back
// until the buffer has room for every line of it
// ======================================================================
`timescale 1ns/1ps
`include "host_mem_settings.svh"

module rsp_credits import host_mem_pkg::*;
(
    input  logic clk,
    input  logic reset,

    input  logic piece_valid,
    input  hm_piece_t piece,
    output logic piece_ready,

    output logic host_req_valid,
    output hm_host_req_t host_req,
    input  logic host_req_ready,

    output logic alloc,
    output hm_slot_t alloc_slot,
    output logic [`HM_PIECE_CNT_W-1:0] alloc_lines,
    output logic [`HM_ID_W-1:0] alloc_id,
    output logic alloc_last,

    input  logic free_lines
);

    localparam int DEPTH = `HM_ROB_DEPTH;
    localparam int CNT_W = $clog2(`HM_ROB_DEPTH + 1);
    // one spare bit so that overflow and underflow stay visible
    localparam int SUM_W = CNT_W + 1;
    localparam int PCNT_W = `HM_PIECE_CNT_W;

    logic [CNT_W-1:0] free_cnt;
    logic [CNT_W-1:0] piece_lines;
    logic [SUM_W-1:0] free_sum;
    hm_slot_t alloc_ptr;
    logic enough;

    assign piece_lines = CNT_W'(piece.len) + 1'b1;
    assign enough = (free_cnt >= piece_lines);

    // the piece passes straight through once its lines are covered
    assign host_req_valid = piece_valid && enough;
    assign piece_ready = host_req_ready && enough;
    assign host_req.addr = piece.addr;
    assign host_req.len = piece.len;
    assign host_req.tag = alloc_ptr;

    // the ROB learns about the slots in the same cycle the host does
    assign alloc = host_req_valid && host_req_ready;
    assign alloc_slot = alloc_ptr;
    assign alloc_lines = PCNT_W'(piece_lines);
    assign alloc_id = piece.id;
    assign alloc_last = piece.last_piece;

    // one line comes back per release, a whole piece leaves per alloc
    assign free_sum = SUM_W'(free_cnt) + SUM_W'(free_lines)
                    - (alloc ? SUM_W'(piece_lines) : '0);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            free_cnt <= CNT_W'(DEPTH);
            alloc_ptr <= '0;
        end
        else
        begin
            free_cnt <= free_sum[CNT_W-1:0];
            if (alloc)
            begin
                alloc_ptr <= alloc_ptr + hm_slot_t'(alloc_lines);
            end
        end
    end

    // an underflow wraps to a large value, so one bound covers both ends
    a_free_range : assert property (@(posedge clk) disable iff (reset)
        free_sum <= SUM_W'(DEPTH));

    // credits only grow while waiting, so an offered request is never pulled
    a_req_held : assert property (@(posedge clk) disable iff (reset)
        host_req_valid && !host_req_ready |=> host_req_valid);

endmodule

// ==== verilog.f ====
+incdir+source
source/host_mem_pkg.sv
source/burst_splitter.sv
source/rsp_credits.sv
source/read_rob.sv
source/host_mem_read_map.sv
bench/host_mem_tb.sv
